//--- project.f
+incdir+sim
hw/lsq_types_pkg.sv
hw/mem_bus_pkg.sv
hw/sq_entry.sv
hw/store_queue.sv
hw/load_unit.sv
hw/mem_arbiter.sv
hw/data_mem.sv
hw/lsq_top.sv
sim/tb_lsq.sv

//--- sim/tb_lsq_model.svh
`ifndef TB_LSQ_MODEL_SVH
`define TB_LSQ_MODEL_SVH

logic [63:0]     model_mem [MEM_WORDS];	// Memory once committed stores drain
logic [63:0]     cdb_value [PRF_SIZE];	// Last data broadcast per tag
logic            cdb_seen [PRF_SIZE];
store_dispatch_t pending [$];	// Dispatched stores in program order
int              model_committed;

function automatic void model_reset();
	for (int i = 0; i < MEM_WORDS; i++) begin
		model_mem[i] = '0;
	end
	for (int i = 0; i < PRF_SIZE; i++) begin
		cdb_seen[i] = 1'b0;
	end
	pending.delete();
	model_committed = 0;
endfunction

function automatic void model_dispatch(input store_dispatch_t s);
	// A tag number may come back after an older use
	if (!s.base.valid) begin
		cdb_seen[s.base.word.tag.prf] = 1'b0;
	end
	if (!s.offset.valid) begin
		cdb_seen[s.offset.word.tag.prf] = 1'b0;
	end
	if (!s.store_data.valid) begin
		cdb_seen[s.store_data.word.tag.prf] = 1'b0;
	end
	pending.push_back(s);
endfunction

function automatic void model_note_cdb(input cdb_t c);
	if (c.valid) begin
		cdb_value[c.tag] = c.data;
		cdb_seen[c.tag]  = 1'b1;
	end
endfunction

function automatic logic operand_known(input operand_t op);
	return op.valid || cdb_seen[op.word.tag.prf];
endfunction

function automatic logic [63:0] operand_value(input operand_t op);
	return op.valid ? op.word.data : cdb_value[op.word.tag.prf];
endfunction

// Oldest committed store with all operands known goes to memory
function automatic void model_apply();
	store_dispatch_t s;
	logic [63:0]     addr;
	while (model_committed > 0 && pending.size() > 0) begin
		s = pending[0];
		if (!(operand_known(s.base) && operand_known(s.offset)
			&& operand_known(s.store_data))) begin
			break;
		end
		addr = operand_value(s.base) + operand_value(s.offset);
		model_mem[addr[10:3]] = operand_value(s.store_data);	// Word index from bits 10 to 3
		void'(pending.pop_front());
		model_committed--;
	end
endfunction

`endif

//--- sim/tb_lsq.sv
`default_nettype none
`timescale 1ns/10ps

module tb_lsq;
	import lsq_types_pkg::*;
	import mem_bus_pkg::*;

	typedef enum {W_DISPATCH, W_DRAINED, W_LOAD_READY, W_LOAD_DONE} wait_sel_t;

	logic            clock;
	logic            reset;
	store_dispatch_t dispatch1;
	store_dispatch_t dispatch2;
	cdb_t            cdb1;
	cdb_t            cdb2;
	logic            commit_store;
	logic            load_valid;
	load_request_t   load_in;
	logic            dispatch_ready;
	logic            sq_drained;
	logic            load_ready;
	logic            load_done;
	load_result_t    load_result;

	int          value_errors;
	int          timeout_errors;
	logic [31:0] lcg_state;
	prf_tag_t    next_tag;	// Tags handed to unresolved operands
	logic [63:0] store_addrs [$];	// Addresses to read back after drain
	cdb_t        to_broadcast [$];

	`include "tb_lsq_model.svh"

	lsq_top uut (.*);

	initial clock = 1'b0;
	always #2 clock = ~clock;

	function automatic logic [15:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[31:16];	// Upper bits are the better ones
	endfunction

	function automatic logic [63:0] rand64();
		return {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
	endfunction

	function automatic operand_t make_operand(input logic [63:0] value, input logic use_tag);
		operand_t op;
		cdb_t     c;
		op.valid     = !use_tag;
		op.word.data = value;
		if (use_tag) begin
			op.word.data    = '0;
			op.word.tag.prf = next_tag;
			c.valid         = 1'b1;
			c.tag           = next_tag;
			c.data          = value;	// Broadcast later on a CDB
			to_broadcast.push_back(c);
			next_tag        = next_tag + 1'b1;
		end
		return op;
	endfunction

	// Mask bits pick tags for base, offset and data
	function automatic store_dispatch_t make_store(input logic [7:0] word,
		input logic [63:0] value, input logic [2:0] tag_mask);
		store_dispatch_t s;
		logic [7:0]      base_word;
		base_word    = 8'(lcg_next() % (16'(word) + 16'd1));
		s.valid      = 1'b1;
		s.base       = make_operand(64'(base_word) << 3, tag_mask[2]);
		s.offset     = make_operand(64'(word - base_word) << 3, tag_mask[1]);
		s.store_data = make_operand(value, tag_mask[0]);
		store_addrs.push_back(64'(word) << 3);
		return s;
	endfunction

	function automatic logic flag_of(input wait_sel_t sel);
		case (sel)
			W_DISPATCH:   return dispatch_ready === 1'b1;
			W_DRAINED:    return sq_drained === 1'b1;
			W_LOAD_READY: return load_ready === 1'b1;
			default:      return load_done === 1'b1;
		endcase
	endfunction

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			value_errors++;
			$display("ERROR %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic check_load(input string name, input load_result_t expected,
		input load_result_t actual);
		if (actual !== expected) begin
			value_errors++;
			$display("ERROR %s: expected tag %0d data %h, actual tag %0d data %h", name,
				expected.dest_tag, expected.data, actual.dest_tag, actual.data);
		end
	endtask

	task automatic wait_high(input wait_sel_t sel, input string what);
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (!flag_of(sel) && cycles < 500) begin
			@(negedge clock);
			cycles++;
		end
		if (!flag_of(sel)) begin
			timeout_errors++;
			$display("Timed out after %0d cycles waiting for %s", cycles, what);
		end
	endtask

	task automatic dispatch_pair(input store_dispatch_t s1, input store_dispatch_t s2);
		wait_high(W_DISPATCH, "dispatch_ready");
		@(posedge clock);
		dispatch1 <= s1;
		dispatch2 <= s2;
		@(posedge clock);
		dispatch1 <= '0;
		dispatch2 <= '0;
		model_dispatch(s1);	// Slot 1 is older
		model_dispatch(s2);
	endtask

	task automatic commit_stores(input int count);
		repeat (count) begin
			@(posedge clock);
			commit_store <= 1'b1;
			@(posedge clock);
			commit_store <= 1'b0;
			model_committed++;
		end
	endtask

	task automatic broadcast_all();
		cdb_t c1;
		cdb_t c2;
		while (to_broadcast.size() > 0) begin
			c1 = to_broadcast.pop_front();
			c2 = (to_broadcast.size() > 0) ? to_broadcast.pop_front() : '0;
			@(posedge clock);
			cdb1 <= c1;
			cdb2 <= c2;
			model_note_cdb(c1);
			model_note_cdb(c2);
		end
		@(posedge clock);
		cdb1 <= '0;
		cdb2 <= '0;
	endtask

	task automatic drain();
		wait_high(W_DRAINED, "sq_drained");
		model_apply();
	endtask

	task automatic do_load(input string name, input logic [63:0] addr,
		input logic [63:0] expected);
		load_request_t req;
		load_result_t  exp;
		req.address  = addr;
		req.dest_tag = prf_tag_t'(lcg_next());
		exp.dest_tag = req.dest_tag;
		exp.data     = expected;
		wait_high(W_LOAD_READY, "load_ready");
		@(posedge clock);
		load_valid <= 1'b1;
		load_in    <= req;
		@(posedge clock);
		load_valid <= 1'b0;
		wait_high(W_LOAD_DONE, "load_done");
		check_load(name, exp, load_result);
	endtask

	task automatic verify_stores(input string name);
		logic [63:0] a;
		while (store_addrs.size() > 0) begin
			a = store_addrs.pop_front();
			do_load(name, a, model_mem[a[10:3]]);
		end
	endtask

	initial begin
		store_dispatch_t s1;
		store_dispatch_t s2;
		logic [7:0]      w;
		logic [63:0]     v1;
		logic [63:0]     v2;
		lcg_state      = 32'd68;
		next_tag       = '0;
		value_errors   = 0;
		timeout_errors = 0;
		reset          = 1'b1;
		dispatch1      = '0;
		dispatch2      = '0;
		cdb1           = '0;
		cdb2           = '0;
		commit_store   = 1'b0;
		load_valid     = 1'b0;
		load_in        = '0;
		model_reset();
		repeat (8) @(posedge clock);
		reset <= 1'b0;

		@(negedge clock);
		check_flag("reset_dispatch_ready", 1'b1, dispatch_ready);
		check_flag("reset_load_ready", 1'b1, load_ready);
		check_flag("reset_drained", 1'b1, sq_drained);
		repeat (2) begin
			w = 8'(lcg_next());
			do_load("reset_load", 64'(w) << 3, 64'd0);
		end

		repeat (2) begin	// Immediate operands only
			s1 = make_store(8'(lcg_next()), rand64(), 3'b000);
			s2 = make_store(8'(lcg_next()), rand64(), 3'b000);
			dispatch_pair(s1, s2);
		end
		commit_stores(4);
		drain();
		verify_stores("immediate_store");

		repeat (3) begin	// Random mix of tags and data
			s1 = make_store(8'(lcg_next()), rand64(), 3'(lcg_next()));
			s2 = make_store(8'(lcg_next()), rand64(), 3'(lcg_next()));
			dispatch_pair(s1, s2);
		end
		commit_stores(6);
		broadcast_all();
		drain();
		verify_stores("tagged_store");

		w  = 8'(lcg_next());
		v1 = rand64();
		v2 = rand64();
		s1 = make_store(w, v1, 3'b000);
		s2 = make_store(w, v2, 3'b000);
		dispatch_pair(s1, s2);
		commit_stores(2);
		drain();
		store_addrs.delete();
		do_load("same_address", 64'(w) << 3, v2);	// Younger slot wins

		s1 = make_store(8'(lcg_next()), rand64(), 3'b000);
		s2 = make_store(8'(lcg_next()), rand64(), 3'b000);
		dispatch_pair(s1, s2);
		@(negedge clock);
		check_flag("uncommitted_drained", 1'b1, sq_drained);
		foreach (store_addrs[i]) begin
			do_load("uncommitted_load", store_addrs[i], model_mem[store_addrs[i][10:3]]);
		end
		commit_stores(2);
		drain();
		verify_stores("committed_store");

		for (int i = 0; i < 4; i += 2) begin	// Stores kept above word 200
			s1 = make_store(8'(240 + i), rand64(), 3'b000);
			s2 = make_store(8'(241 + i), rand64(), 3'b000);
			dispatch_pair(s1, s2);
		end
		commit_stores(4);
		repeat (4) begin
			w = 8'(lcg_next() % 16'd200);
			do_load("contention_load", 64'(w) << 3, model_mem[w]);
		end
		drain();
		verify_stores("contention_store");

		$display("Checks done: %0d value errors, %0d timeouts", value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0) begin
			$display("SIMULATION PASSED");
		end
		else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- hw/lsq_top.sv
`default_nettype none
`timescale 1ns/10ps

module lsq_top (
	input  logic                           clock,
	input  logic                           reset,
	input  lsq_types_pkg::store_dispatch_t dispatch1,
	input  lsq_types_pkg::store_dispatch_t dispatch2,
	input  lsq_types_pkg::cdb_t            cdb1,
	input  lsq_types_pkg::cdb_t            cdb2,
	input  logic                           commit_store,
	input  logic                           load_valid,
	input  lsq_types_pkg::load_request_t   load_in,
	output logic                           dispatch_ready,
	output logic                           sq_drained,
	output logic                           load_ready,
	output logic                           load_done,
	output lsq_types_pkg::load_result_t    load_result
);
	import mem_bus_pkg::*;

	logic         store_req, store_ack;
	logic         load_req, load_ack;
	logic         mem_req, mem_ack;
	logic [63:0]  mem_rdata;
	mem_request_t store_request;
	mem_request_t load_request;
	mem_request_t mem_request;	// Granted side

	store_queue u_store_queue (
		.clock          (clock),
		.reset          (reset),
		.dispatch1      (dispatch1),
		.dispatch2      (dispatch2),
		.cdb1           (cdb1),
		.cdb2           (cdb2),
		.commit_store   (commit_store),
		.mem_ack        (store_ack),
		.dispatch_ready (dispatch_ready),
		.sq_drained     (sq_drained),
		.mem_req        (store_req),
		.mem_request    (store_request)
	);

	load_unit u_load_unit (
		.clock       (clock),
		.reset       (reset),
		.load_valid  (load_valid),
		.load_in     (load_in),
		.mem_ack     (load_ack),
		.mem_rdata   (mem_rdata),
		.load_ready  (load_ready),
		.mem_req     (load_req),
		.mem_request (load_request),
		.load_done   (load_done),
		.load_result (load_result)
	);

	mem_arbiter u_mem_arbiter (
		.clock         (clock),
		.reset         (reset),
		.store_req     (store_req),
		.store_request (store_request),
		.load_req      (load_req),
		.load_request  (load_request),
		.mem_ack       (mem_ack),
		.store_ack     (store_ack),
		.load_ack      (load_ack),
		.mem_req       (mem_req),
		.mem_request   (mem_request)
	);

	data_mem u_data_mem (
		.clock       (clock),
		.reset       (reset),
		.mem_req     (mem_req),
		.mem_request (mem_request),
		.mem_ack     (mem_ack),
		.mem_rdata   (mem_rdata)
	);

endmodule

`default_nettype wire

//--- hw/data_mem.sv
`default_nettype none
`timescale 1ns/10ps

module data_mem (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      mem_req,
	input  mem_bus_pkg::mem_request_t mem_request,
	output logic                      mem_ack,
	output logic [63:0]               mem_rdata
);
	import mem_bus_pkg::*;

	logic [63:0] mem_array [MEM_WORDS];

	always_ff @(posedge clock) begin
		if (reset) begin
			mem_ack <= 1'b0;
			for (int i = 0; i < MEM_WORDS; i++) begin
				mem_array[i] <= '0;	// Memory starts cleared
			end
		end
		else if (mem_req && !mem_ack) begin
			mem_ack <= 1'b1;
			if (mem_request.write) begin
				mem_array[mem_request.addr] <= mem_request.wdata;
			end
			else begin
				mem_rdata <= mem_array[mem_request.addr];	// Held while ack high
			end
		end
		else if (!mem_req && mem_ack) begin
			mem_ack <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- hw/mem_arbiter.sv
`default_nettype none
`timescale 1ns/10ps

module mem_arbiter (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      store_req,
	input  mem_bus_pkg::mem_request_t store_request,
	input  logic                      load_req,
	input  mem_bus_pkg::mem_request_t load_request,
	input  logic                      mem_ack,
	output logic                      store_ack,
	output logic                      load_ack,
	output logic                      mem_req,
	output mem_bus_pkg::mem_request_t mem_request
);

	logic locked;
	logic last_load;	// Load side holds or last held the bus
	logic pick_load;
	logic grant_load;

	// Round robin only matters when both ask
	assign pick_load  = load_req && (!store_req || !last_load);
	assign grant_load = locked ? last_load : pick_load;

	assign mem_req     = grant_load ? load_req : store_req;
	assign mem_request = grant_load ? load_request : store_request;
	assign store_ack   = mem_ack && !grant_load;
	assign load_ack    = mem_ack && grant_load;

	always_ff @(posedge clock) begin
		if (reset) begin
			locked    <= 1'b0;
			last_load <= 1'b0;
		end
		else if (!locked) begin
			if (store_req || load_req) begin
				locked    <= 1'b1;
				last_load <= pick_load;
			end
		end
		else if (!mem_req && !mem_ack) begin
			locked <= 1'b0;	// Four phases done
		end
	end

	// Ack only arrives while one side holds the lock
	a_ack_locked: assert property (
		@(posedge clock) disable iff (reset) mem_ack |-> locked
	);

	// Requester holds its payload until ack
	a_payload_stable: assert property (
		@(posedge clock) disable iff (reset)
		(mem_req && $past(mem_req)) |-> (mem_request == $past(mem_request))
	);

endmodule

`default_nettype wire

//--- hw/load_unit.sv
`default_nettype none
`timescale 1ns/10ps

module load_unit (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         load_valid,
	input  lsq_types_pkg::load_request_t load_in,
	input  logic                         mem_ack,
	input  logic [63:0]                  mem_rdata,
	output logic                         load_ready,
	output logic                         mem_req,
	output mem_bus_pkg::mem_request_t    mem_request,
	output logic                         load_done,
	output lsq_types_pkg::load_result_t  load_result
);
	import mem_bus_pkg::*;

	typedef enum logic [1:0] {LD_IDLE, LD_REQ, LD_REL} ld_state_t;

	ld_state_t state;
	logic      accept;

	assign accept     = load_valid && load_ready;
	assign load_ready = (state == LD_IDLE);
	assign mem_req    = (state == LD_REQ);

	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= LD_IDLE;
			load_done <= 1'b0;
		end
		else begin
			load_done <= 1'b0;
			case (state)
				LD_IDLE: if (accept) state <= LD_REQ;
				LD_REQ:  if (mem_ack) state <= LD_REL;
				LD_REL: begin
					if (!mem_ack) begin	// Handshake complete
						state     <= LD_IDLE;
						load_done <= 1'b1;
					end
				end
				default: state <= LD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			mem_request.write    <= 1'b0;
			mem_request.addr     <= load_in.address[WORD_LSB +: $bits(word_addr_t)];
			mem_request.wdata    <= '0;
			load_result.dest_tag <= load_in.dest_tag;
		end
		if ((state == LD_REQ) && mem_ack) begin
			load_result.data <= mem_rdata;	// Valid while ack high
		end
	end

endmodule

`default_nettype wire

//--- hw/store_queue.sv
`default_nettype none
`timescale 1ns/10ps

module store_queue (
	input  logic                           clock,
	input  logic                           reset,
	input  lsq_types_pkg::store_dispatch_t dispatch1,
	input  lsq_types_pkg::store_dispatch_t dispatch2,
	input  lsq_types_pkg::cdb_t            cdb1,
	input  lsq_types_pkg::cdb_t            cdb2,
	input  logic                           commit_store,
	input  logic                           mem_ack,
	output logic                           dispatch_ready,
	output logic                           sq_drained,
	output logic                           mem_req,
	output mem_bus_pkg::mem_request_t      mem_request
);
	import lsq_types_pkg::*;
	import mem_bus_pkg::*;

	typedef logic [$clog2(SQ_DEPTH):0] count_t;
	typedef enum logic [1:0] {SQ_IDLE, SQ_REQ, SQ_REL} sq_state_t;

	sq_state_t             state;
	sq_idx_t               head;
	sq_idx_t               tail;
	sq_idx_t               alloc2_idx;
	count_t                free_count;
	count_t                committed_count;
	count_t                alloc_count;
	logic [SQ_DEPTH-1:0]   entry_alloc;
	logic [SQ_DEPTH-1:0]   entry_free;
	logic [SQ_DEPTH-1:0]   entry_in_use;
	logic [SQ_DEPTH-1:0]   entry_ready;
	logic [63:0]           entry_address [SQ_DEPTH];
	logic [63:0]           entry_value [SQ_DEPTH];
	logic                  issue;
	logic                  drain_done;

	assign alloc2_idx  = tail + sq_idx_t'(dispatch1.valid);	// Slot 2 lands behind slot 1
	assign alloc_count = count_t'(dispatch1.valid) + count_t'(dispatch2.valid);

	assign issue      = (state == SQ_IDLE) && (committed_count != '0) && entry_ready[head];
	assign drain_done = (state == SQ_REL) && !mem_ack;	// Ack has fallen

	for (genvar i = 0; i < SQ_DEPTH; i++) begin : g_entry
		logic            take1;
		store_dispatch_t entry_in;

		assign take1          = dispatch1.valid && (tail == sq_idx_t'(i));
		assign entry_alloc[i] = take1 || (dispatch2.valid && (alloc2_idx == sq_idx_t'(i)));
		assign entry_free[i]  = drain_done && (head == sq_idx_t'(i));
		assign entry_in       = take1 ? dispatch1 : dispatch2;

		sq_entry u_entry (
			.clock          (clock),
			.reset          (reset),
			.allocate       (entry_alloc[i]),
			.store_in       (entry_in),
			.free           (entry_free[i]),
			.cdb1           (cdb1),
			.cdb2           (cdb2),
			.in_use         (entry_in_use[i]),
			.operands_ready (entry_ready[i]),
			.mem_address    (entry_address[i]),
			.store_value    (entry_value[i])
		);

		// Tail never wraps onto a live store
		a_no_overwrite: assert property (
			@(posedge clock) disable iff (reset) entry_alloc[i] |-> !entry_in_use[i]
		);
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state           <= SQ_IDLE;
			head            <= '0;
			tail            <= '0;
			free_count      <= count_t'(SQ_DEPTH);
			committed_count <= '0;
		end
		else begin
			tail            <= tail + sq_idx_t'(alloc_count);
			free_count      <= free_count - alloc_count + count_t'(drain_done);
			committed_count <= committed_count + count_t'(commit_store)
				- count_t'(drain_done);
			case (state)
				SQ_IDLE: if (issue) state <= SQ_REQ;
				SQ_REQ:  if (mem_ack) state <= SQ_REL;	// Drop req after ack
				SQ_REL: begin
					if (!mem_ack) begin
						state <= SQ_IDLE;
						head  <= head + 1'b1;
					end
				end
				default: state <= SQ_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (issue) begin
			mem_request.write <= 1'b1;
			mem_request.addr  <= entry_address[head][WORD_LSB +: $bits(word_addr_t)];
			mem_request.wdata <= entry_value[head];
		end
	end

	assign mem_req        = (state == SQ_REQ);
	assign dispatch_ready = (free_count >= count_t'(2));
	assign sq_drained     = (committed_count == '0);

	a_dispatch_when_ready: assert property (
		@(posedge clock) disable iff (reset)
		(dispatch1.valid || dispatch2.valid) |-> dispatch_ready
	);

	// ROB never commits a store the queue does not hold
	a_commit_bound: assert property (
		@(posedge clock) disable iff (reset)
		committed_count <= count_t'(SQ_DEPTH) - free_count
	);

endmodule

`default_nettype wire

//--- hw/sq_entry.sv
`default_nettype none
`timescale 1ns/10ps

module sq_entry (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           allocate,
	input  lsq_types_pkg::store_dispatch_t store_in,
	input  logic                           free,
	input  lsq_types_pkg::cdb_t            cdb1,
	input  lsq_types_pkg::cdb_t            cdb2,
	output logic                           in_use,
	output logic                           operands_ready,
	output logic [63:0]                    mem_address,
	output logic [63:0]                    store_value
);
	import lsq_types_pkg::*;

	store_dispatch_t held;

	// Wake one operand from whichever bus carries its tag
	function automatic operand_t snoop(
		input operand_t op,
		input cdb_t     c1,
		input cdb_t     c2
	);
		operand_t result;
		result = op;
		if (!op.valid && c1.valid && (op.word.tag.prf == c1.tag)) begin
			result.valid     = 1'b1;
			result.word.data = c1.data;
		end
		else if (!op.valid && c2.valid && (op.word.tag.prf == c2.tag)) begin
			result.valid     = 1'b1;
			result.word.data = c2.data;
		end
		return result;
	endfunction

	always_ff @(posedge clock) begin
		if (reset) begin
			in_use <= 1'b0;
		end
		else if (allocate) begin
			in_use <= 1'b1;
		end
		else if (free) begin
			in_use <= 1'b0;
		end
	end

	// Store payload and operand wakeup
	always_ff @(posedge clock) begin
		if (allocate) begin
			held <= store_in;	// Broadcasts this cycle are not captured
		end
		else if (in_use) begin
			held.base       <= snoop(held.base, cdb1, cdb2);
			held.offset     <= snoop(held.offset, cdb1, cdb2);
			held.store_data <= snoop(held.store_data, cdb1, cdb2);
		end
	end

	assign operands_ready = in_use && held.base.valid && held.offset.valid
		&& held.store_data.valid;
	assign mem_address    = held.base.word.data + held.offset.word.data;
	assign store_value    = held.store_data.word.data;

	// Queue never reuses an entry in the cycle it drains it
	a_no_alloc_on_free: assert property (
		@(posedge clock) disable iff (reset) !(allocate && free)
	);

endmodule

`default_nettype wire

//--- hw/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

	localparam int MEM_WORDS = 256;
	localparam int WORD_LSB  = 3;	// Bytes within a 64-bit word

	typedef logic [$clog2(MEM_WORDS)-1:0] word_addr_t;

	typedef struct packed {
		logic        write;
		word_addr_t  addr;
		logic [63:0] wdata;
	} mem_request_t;

endpackage

`default_nettype wire

//--- hw/lsq_types_pkg.sv
`default_nettype none

package lsq_types_pkg;

	localparam int PRF_SIZE = 64;
	localparam int SQ_DEPTH = 8;

	typedef logic [$clog2(PRF_SIZE)-1:0] prf_tag_t;
	typedef logic [$clog2(SQ_DEPTH)-1:0] sq_idx_t;

	typedef struct packed {
		logic [57:0] pad;
		prf_tag_t    prf;
	} operand_tag_t;

	// Operand word read either as a value or as a pending register tag
	typedef union packed {
		logic [63:0]  data;
		operand_tag_t tag;
	} operand_word_u;

	typedef struct packed {
		logic          valid;	// Set when word holds data
		operand_word_u word;
	} operand_t;

	typedef struct packed {
		logic     valid;
		operand_t base;
		operand_t offset;
		operand_t store_data;
	} store_dispatch_t;

	typedef struct packed {
		logic        valid;
		prf_tag_t    tag;
		logic [63:0] data;
	} cdb_t;

	typedef struct packed {
		logic [63:0] address;
		prf_tag_t    dest_tag;
	} load_request_t;

	typedef struct packed {
		prf_tag_t    dest_tag;
		logic [63:0] data;
	} load_result_t;

endpackage

`default_nettype wire
